//--- Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing -Wno-fatal
TOP        = tb_blackjack
DUT_TOP    = blackjack_sim
FILELIST   = blackjack_sim.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bj_checker.sv
// Result checker for the blackjack engine
// Watches the DUT ports: reset values, load count, every report against
// the game rules and the table row, report counts per lane and per test

`timescale 1ns/1ps

module bj_checker import bj_pkg::*; #(
	parameter int NUM_LANES = 4,
	localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
	input  logic              CLOCK_50,
	input  logic              reset,
	input  logic              load_ack,
	input  logic              deck_loaded,
	input  logic              busy,
	input  logic              result_req,
	input  logic [LANE_W-1:0] result_lane,
	input  logic [HAND_W-1:0] result_player,
	input  logic [HAND_W-1:0] result_dealer,
	input  outcome_t          result_outcome,
	input  logic [127:0]      test_name,
	input  logic [GAME_W-1:0] games_per_lane,
	input  logic              exp_any,
	input  logic [HAND_W-1:0] exp_player,
	input  logic [HAND_W-1:0] exp_dealer,
	input  outcome_t          exp_outcome,
	input  logic              test_end,
	input  logic              run_end,
	output int                error_count
);

	logic reset_q = 1'b0;
	logic ack_q = 1'b0;
	logic loaded_q = 1'b0;
	logic req_q = 1'b0;
	int   acks = 0;
	int   reports = 0;
	int   lane_reports [NUM_LANES];
	int   errors_before = 0;
	int   tests_run = 0;
	int   tests_failed = 0;

	initial error_count = 0;

	// Packed name back to text without the zero bytes
	function automatic string name_text(input logic [127:0] packed_name);
		string s;
		s = "";
		for (int b = 15; b >= 0; b--) begin
			if (packed_name[8 * b +: 8] != 8'h00) begin
				s = $sformatf("%s%c", s, packed_name[8 * b +: 8]);
			end
		end
		return s;
	endfunction

	// Player bust first, then dealer bust, then compare
	function automatic outcome_t expected_outcome(input int p, input int d);
		if (p > 21) begin
			return LOSS;
		end
		if (d > 21 || p > d) begin
			return WIN;
		end
		if (p == d) begin
			return TIE;
		end
		return LOSS;
	endfunction

	task automatic value_error(input string what, input int expected, input int actual);
		error_count++;
		$display("error %s: %s expected %0d actual %0d", name_text(test_name), what,
			expected, actual);
	endtask

	task automatic rule_error(input string what);
		error_count++;
		$display("error %s: %s", name_text(test_name), what);
	endtask

	task automatic check_report();
		int p;
		int d;
		int lane;
		p    = int'(result_player);
		d    = int'(result_dealer);
		lane = int'(result_lane);
		reports++;
		lane_reports[lane]++;
		if (result_outcome != expected_outcome(p, d)) begin
			value_error("outcome", int'(expected_outcome(p, d)), int'(result_outcome));
		end
		if (p < 12 || p > 30) begin
			rule_error($sformatf("player total %0d outside 12 to 30", p));
		end
		// Bust hand keeps only the up card on the dealer side
		if (p > 21 && (d < 2 || d > 11)) begin
			rule_error($sformatf("dealer total %0d after a player bust", d));
		end
		if (p <= 21 && d < DEALER_STAND) begin
			rule_error($sformatf("dealer stopped at %0d", d));
		end
		if (!exp_any) begin
			if (result_player != exp_player) begin
				value_error("player total", int'(exp_player), p);
			end
			if (result_dealer != exp_dealer) begin
				value_error("dealer total", int'(exp_dealer), d);
			end
			if (result_outcome != exp_outcome) begin
				value_error("table outcome", int'(exp_outcome), int'(result_outcome));
			end
		end
	endtask

	// Count checks and the one-line summary of a test
	task automatic finish_test();
		int test_errors;
		if (reports != NUM_LANES * int'(games_per_lane)) begin
			value_error("report count", NUM_LANES * int'(games_per_lane), reports);
		end
		for (int k = 0; k < NUM_LANES; k++) begin
			if (lane_reports[k] != int'(games_per_lane)) begin
				value_error($sformatf("lane %0d report count", k), int'(games_per_lane),
					lane_reports[k]);
			end
		end
		test_errors   = error_count - errors_before;
		errors_before = error_count;
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
		end
		$display("test %s: %s, %0d reports, %0d errors", name_text(test_name),
			(test_errors == 0) ? "ok" : "FAILED", reports, test_errors);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Port monitor
	//////////////////////////////////////////////////////////////////////

	always @(posedge CLOCK_50) begin
		// Outputs cleared one cycle into reset
		if (reset && reset_q) begin
			if (load_ack !== 1'b0) value_error("load_ack in reset", 0, int'(load_ack));
			if (result_req !== 1'b0) value_error("result_req in reset", 0, int'(result_req));
			if (busy !== 1'b0) value_error("busy in reset", 0, int'(busy));
			if (deck_loaded !== 1'b0) value_error("deck_loaded in reset", 0, int'(deck_loaded));
		end
		if (reset) begin
			acks    = 0;
			reports = 0;
			for (int k = 0; k < NUM_LANES; k++) begin
				lane_reports[k] = 0;
			end
		end else begin
			if (load_ack && !ack_q) begin
				acks++;
			end
			// Flag rises with the last ack
			if (deck_loaded && !loaded_q && acks != DECK_SIZE) begin
				value_error("load handshakes at deck_loaded", DECK_SIZE, acks);
			end
			if (result_req && !req_q) begin
				check_report();
			end
		end
		if (test_end) begin
			finish_test();
		end
		if (run_end) begin
			$display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run,
				tests_run - tests_failed, tests_failed, error_count);
		end
		reset_q  <= reset;
		ack_q    <= load_ack;
		loaded_q <= deck_loaded;
		req_q    <= result_req;
	end

endmodule

//--- bj_pkg.sv
// Blackjack engine shared definitions
// Deck, hand and count widths, game limits, lane FSM states and outcomes

package bj_pkg;

	//////////////////////////////////////////////////////////////////////
	// Deck and hand sizing
	//////////////////////////////////////////////////////////////////////

	// One standard deck
	localparam int DECK_SIZE = 52;
	// Card value 2..11, ace counted as deck value
	localparam int CARD_W = 4;
	// Index into deck memory, 64 slots
	localparam int IDX_W = 6;
	// Hand total, worst case 16 + 11
	localparam int HAND_W = 5;
	// Games per lane per run
	localparam int GAME_W = 16;

	//////////////////////////////////////////////////////////////////////
	// Game limits
	//////////////////////////////////////////////////////////////////////

	// Player stands here whatever the up card
	localparam int STAND_HARD = 17;
	// Dealer stops drawing here
	localparam int DEALER_STAND = 17;
	// Anything above busts
	localparam int BUST_LIMIT = 21;

	// Per-lane game FSM
	typedef enum logic [3:0] {
		IDLE,
		DRAW,
		WAIT_RAM,
		DEALER_UP,
		PLAYER_DRAW,
		PLAYER_TAKE,
		DEALER_DRAW,
		DEALER_TAKE,
		JUDGE,
		REPORT
	} lane_state_t;

	// Result seen from the player side
	typedef enum logic [1:0] {
		LOSS,
		TIE,
		WIN
	} outcome_t;

endpackage

//--- blackjack_sim.f
bj_pkg.sv
deck_loader.sv
card_rng.sv
deck_store.sv
hand_sequencer.sv
result_arbiter.sv
blackjack_sim.sv
bj_checker.sv
tb_blackjack.sv

//--- blackjack_sim.sv
// Monte Carlo blackjack engine top
// Deck loader, parallel game lanes each with RNG and deck store,
// and the round-robin result arbiter

`timescale 1ns/1ps

module blackjack_sim import bj_pkg::*; #(
	parameter int NUM_LANES = 4,
	localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
	input  logic              CLOCK_50,
	input  logic              reset,
	input  logic              load_req,
	input  logic [CARD_W-1:0] load_value,
	input  logic              start,
	input  logic [GAME_W-1:0] games_per_lane,
	input  logic              result_ack,
	output logic              load_ack,
	output logic              deck_loaded,
	output logic              busy,
	output logic              result_req,
	output logic [LANE_W-1:0] result_lane,
	output logic [HAND_W-1:0] result_player,
	output logic [HAND_W-1:0] result_dealer,
	output outcome_t          result_outcome
);

	// Loader broadcast
	logic              wr_en;
	logic [IDX_W-1:0]  wr_index;
	logic [CARD_W-1:0] wr_value;

	// Per-lane wiring
	logic [7:0]           rand_out [NUM_LANES];
	logic [IDX_W-1:0]     rd_index [NUM_LANES];
	logic [IDX_W-1:0]     probe_index [NUM_LANES];
	logic [CARD_W-1:0]    rd_value [NUM_LANES];
	logic [NUM_LANES-1:0] take;
	logic [NUM_LANES-1:0] clear_mask;
	logic [NUM_LANES-1:0] probe_dealt;
	logic [NUM_LANES-1:0] lane_done;
	logic [NUM_LANES-1:0] rep_req;
	logic [NUM_LANES-1:0] rep_ack;
	logic [HAND_W-1:0]    rep_player [NUM_LANES];
	logic [HAND_W-1:0]    rep_dealer [NUM_LANES];
	outcome_t             rep_outcome [NUM_LANES];

	logic arb_idle;
	logic start_ok;

	// Run accepted only with a full deck and no run going
	assign start_ok = start && deck_loaded && !busy;

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (start_ok) begin
			busy <= 1'b1;
		end else if (busy && (&lane_done) && arb_idle) begin
			busy <= 1'b0;
		end
	end

	deck_loader u_loader (
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.load_req    (load_req),
		.load_value  (load_value),
		.load_ack    (load_ack),
		.deck_loaded (deck_loaded),
		.wr_en       (wr_en),
		.wr_index    (wr_index),
		.wr_value    (wr_value)
	);

	//////////////////////////////////////////////////////////////////////
	// Game lanes
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		card_rng #(.LANE_ID(i)) u_rng (
			.CLOCK_50 (CLOCK_50),
			.reset    (reset),
			.rand_out (rand_out[i])
		);

		deck_store u_deck (
			.CLOCK_50    (CLOCK_50),
			.reset       (reset),
			.wr_en       (wr_en),
			.wr_index    (wr_index),
			.wr_value    (wr_value),
			.rd_index    (rd_index[i]),
			.take        (take[i]),
			.clear_mask  (clear_mask[i]),
			.probe_index (probe_index[i]),
			.rd_value    (rd_value[i]),
			.probe_dealt (probe_dealt[i])
		);

		hand_sequencer u_seq (
			.CLOCK_50       (CLOCK_50),
			.reset          (reset),
			.start_game     (start_ok),
			.games_per_lane (games_per_lane),
			.rand_out       (rand_out[i]),
			.rd_value       (rd_value[i]),
			.probe_dealt    (probe_dealt[i]),
			.rep_ack        (rep_ack[i]),
			.rd_index       (rd_index[i]),
			.take           (take[i]),
			.clear_mask     (clear_mask[i]),
			.probe_index    (probe_index[i]),
			.lane_done      (lane_done[i]),
			.rep_req        (rep_req[i]),
			.rep_player     (rep_player[i]),
			.rep_dealer     (rep_dealer[i]),
			.rep_outcome    (rep_outcome[i])
		);
	end

	result_arbiter #(.NUM_LANES(NUM_LANES)) u_arb (
		.CLOCK_50       (CLOCK_50),
		.reset          (reset),
		.rep_req        (rep_req),
		.rep_player     (rep_player),
		.rep_dealer     (rep_dealer),
		.rep_outcome    (rep_outcome),
		.result_ack     (result_ack),
		.rep_ack        (rep_ack),
		.result_req     (result_req),
		.result_lane    (result_lane),
		.result_player  (result_player),
		.result_dealer  (result_dealer),
		.result_outcome (result_outcome),
		.idle           (arb_idle)
	);

endmodule

//--- card_rng.sv
// Lane random source
// Eight coupled 8-bit shift registers, 64 bits of state,
// one fresh 8-bit draw every clock

`timescale 1ns/1ps

module card_rng #(
	parameter int LANE_ID = 0
) (
	input  logic       CLOCK_50,
	input  logic       reset,
	output logic [7:0] rand_out
);

	// Base seed, lane number folded into the low bits
	localparam logic [64:1] SEED = 64'h5455_5555_9e37_79b9 ^ 64'(LANE_ID);

	logic [8:1] sr [1:8];

	// One bit from each register
	always_comb begin
		for (int k = 1; k <= 8; k++) begin
			rand_out[8 - k] = sr[k][7];
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			for (int k = 1; k <= 8; k++) begin
				sr[k] <= SEED[8 * k -: 8];
			end
		end else begin
			// First register wraps around to the last one
			sr[1] <= {sr[1][7:1], sr[1][7] ^ sr[8][7]};
			// Rest take the top bit of the one below
			for (int k = 2; k <= 8; k++) begin
				sr[k] <= {sr[k][7:1], sr[k][7] ^ sr[k - 1][8]};
			end
		end
	end

endmodule

//--- deck_loader.sv
// Deck loader
// Takes card values from the host over a four-phase req/ack handshake
// and broadcasts each one as a write to every lane's deck store

`timescale 1ns/1ps

module deck_loader import bj_pkg::*; (
	input  logic              CLOCK_50,
	input  logic              reset,
	input  logic              load_req,
	input  logic [CARD_W-1:0] load_value,
	output logic              load_ack,
	output logic              deck_loaded,
	output logic              wr_en,
	output logic [IDX_W-1:0]  wr_index,
	output logic [CARD_W-1:0] wr_value
);

	typedef enum logic [1:0] {
		LD_IDLE,
		LD_WRITE,
		LD_ACK
	} load_state_t;

	load_state_t state;

	// Value capture, no reset needed
	always_ff @(posedge CLOCK_50) begin
		if (state == LD_IDLE && load_req) begin
			wr_value <= load_value;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			state       <= LD_IDLE;
			load_ack    <= 1'b0;
			deck_loaded <= 1'b0;
			wr_en       <= 1'b0;
			wr_index    <= '0;
		end else begin
			case (state)
				// Request seen, write goes out next cycle
				LD_IDLE: begin
					if (load_req) begin
						// Full deck already here, handshake only
						wr_en <= ~deck_loaded;
						state <= LD_WRITE;
					end
				end
				// Write done, step index and acknowledge
				LD_WRITE: begin
					wr_en    <= 1'b0;
					load_ack <= 1'b1;
					if (wr_en) begin
						wr_index <= wr_index + 1'b1;
						if (wr_index == IDX_W'(DECK_SIZE - 1)) begin
							deck_loaded <= 1'b1;
						end
					end
					state <= LD_ACK;
				end
				// Host must drop req before the next card
				LD_ACK: begin
					if (!load_req) begin
						load_ack <= 1'b0;
						state    <= LD_IDLE;
					end
				end
				default: state <= LD_IDLE;
			endcase
		end
	end

endmodule

//--- deck_store.sv
// Lane deck store
// Card value memory with a registered read port, plus the mask of
// cards already dealt in the current game

`timescale 1ns/1ps

module deck_store import bj_pkg::*; (
	input  logic              CLOCK_50,
	input  logic              reset,
	input  logic              wr_en,
	input  logic [IDX_W-1:0]  wr_index,
	input  logic [CARD_W-1:0] wr_value,
	input  logic [IDX_W-1:0]  rd_index,
	input  logic              take,
	input  logic              clear_mask,
	input  logic [IDX_W-1:0]  probe_index,
	output logic [CARD_W-1:0] rd_value,
	output logic              probe_dealt
);

	logic [CARD_W-1:0]    mem [0:(1 << IDX_W) - 1];
	logic [DECK_SIZE-1:0] dealt;

	// Host writes and lane reads share the store
	always_ff @(posedge CLOCK_50) begin
		if (wr_en) begin
			mem[wr_index] <= wr_value;
		end
		// Value valid one cycle after the index
		rd_value <= mem[rd_index];
	end

	always_ff @(posedge CLOCK_50) begin
		if (reset || clear_mask) begin
			dealt <= '0;
		end else if (take && rd_index < IDX_W'(DECK_SIZE)) begin
			dealt[rd_index] <= 1'b1;
		end
	end

	// Slots past the deck count as taken so the draw retries
	assign probe_dealt = (probe_index >= IDX_W'(DECK_SIZE)) ? 1'b1 : dealt[probe_index];

endmodule

//--- hand_sequencer.sv
// Lane game sequencer
// Draws the dealer up card, plays the player by the fixed stand rule,
// lets the dealer hit to 17, judges, reports and repeats per game count

`timescale 1ns/1ps

module hand_sequencer import bj_pkg::*; (
	input  logic              CLOCK_50,
	input  logic              reset,
	input  logic              start_game,
	input  logic [GAME_W-1:0] games_per_lane,
	input  logic [7:0]        rand_out,
	input  logic [CARD_W-1:0] rd_value,
	input  logic              probe_dealt,
	input  logic              rep_ack,
	output logic [IDX_W-1:0]  rd_index,
	output logic              take,
	output logic              clear_mask,
	output logic [IDX_W-1:0]  probe_index,
	output logic              lane_done,
	output logic              rep_req,
	output logic [HAND_W-1:0] rep_player,
	output logic [HAND_W-1:0] rep_dealer,
	output outcome_t          rep_outcome
);

	lane_state_t       state;
	lane_state_t       ret_state;
	logic [HAND_W-1:0] player_total;
	logic [HAND_W-1:0] dealer_total;
	logic [CARD_W-1:0] up_card;
	logic [GAME_W-1:0] games_done;
	logic [HAND_W-1:0] card_ext;
	logic              last_game;

	// Basic strategy subset on hard totals
	function automatic logic player_stands(input logic [HAND_W-1:0] total,
			input logic [CARD_W-1:0] up);
		logic weak_up;
		logic very_weak_up;
		weak_up      = (up >= 2) && (up <= 6);
		very_weak_up = (up >= 4) && (up <= 6);
		return (total >= STAND_HARD) ||
			(total == 12 && very_weak_up) ||
			(total >= 13 && total <= 16 && weak_up);
	endfunction

	// Low six bits of the draw pick the slot
	assign probe_index = rand_out[IDX_W-1:0];
	assign card_ext    = HAND_W'(rd_value);
	assign last_game   = (GAME_W'(games_done + 1'b1) == games_per_lane);

	// Totals stay put through REPORT
	assign rep_player = player_total;
	assign rep_dealer = dealer_total;

	// Mark card dealt as it is added
	assign take = (state == DEALER_UP) || (state == PLAYER_TAKE) || (state == DEALER_TAKE);
	// Fresh mask for every game
	assign clear_mask = (state == IDLE && start_game && games_per_lane != '0) ||
		(state == REPORT && rep_ack && !last_game);

	// Payload side, no reset
	always_ff @(posedge CLOCK_50) begin
		// Accepted draw, latch slot for the memory read
		if ((state == DRAW || state == PLAYER_DRAW || state == DEALER_DRAW) && !probe_dealt) begin
			rd_index <= probe_index;
		end
		if (clear_mask) begin
			player_total <= '0;
			dealer_total <= '0;
		end else if (state == DEALER_UP) begin
			up_card      <= rd_value;
			dealer_total <= card_ext;
		end else if (state == PLAYER_TAKE) begin
			player_total <= player_total + card_ext;
		end else if (state == DEALER_TAKE) begin
			dealer_total <= dealer_total + card_ext;
		end
		// Bust first, then dealer bust, then compare
		if (state == JUDGE) begin
			if (player_total > BUST_LIMIT) begin
				rep_outcome <= LOSS;
			end else if (dealer_total > BUST_LIMIT || player_total > dealer_total) begin
				rep_outcome <= WIN;
			end else if (player_total == dealer_total) begin
				rep_outcome <= TIE;
			end else begin
				rep_outcome <= LOSS;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Game FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			state      <= IDLE;
			ret_state  <= IDLE;
			rep_req    <= 1'b0;
			lane_done  <= 1'b1;
			games_done <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (start_game) begin
						games_done <= '0;
						// Zero games means nothing to play
						if (games_per_lane != '0) begin
							lane_done <= 1'b0;
							state     <= DRAW;
						end
					end
				end
				// Dealer up card, retry on a bad slot
				DRAW: begin
					if (!probe_dealt) begin
						ret_state <= DEALER_UP;
						state     <= WAIT_RAM;
					end
				end
				// Memory read in flight
				WAIT_RAM: state <= ret_state;
				DEALER_UP: state <= PLAYER_DRAW;
				PLAYER_DRAW: begin
					if (player_total > BUST_LIMIT) begin
						// Busted, dealer keeps the up card only
						state <= JUDGE;
					end else if (player_stands(player_total, up_card)) begin
						state <= DEALER_DRAW;
					end else if (!probe_dealt) begin
						ret_state <= PLAYER_TAKE;
						state     <= WAIT_RAM;
					end
				end
				PLAYER_TAKE: state <= PLAYER_DRAW;
				DEALER_DRAW: begin
					if (dealer_total >= DEALER_STAND) begin
						state <= JUDGE;
					end else if (!probe_dealt) begin
						ret_state <= DEALER_TAKE;
						state     <= WAIT_RAM;
					end
				end
				DEALER_TAKE: state <= DEALER_DRAW;
				JUDGE: begin
					rep_req <= 1'b1;
					state   <= REPORT;
				end
				// Hold report until the arbiter takes it
				REPORT: begin
					if (rep_ack) begin
						rep_req    <= 1'b0;
						games_done <= games_done + 1'b1;
						if (last_game) begin
							lane_done <= 1'b1;
							state     <= IDLE;
						end else begin
							state <= DRAW;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- result_arbiter.sv
// Result arbiter
// Round-robin pick among lanes holding a report, then passes the
// report to the host over a four-phase req/ack handshake

`timescale 1ns/1ps

module result_arbiter import bj_pkg::*; #(
	parameter int NUM_LANES = 4,
	localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
	input  logic                 CLOCK_50,
	input  logic                 reset,
	input  logic [NUM_LANES-1:0] rep_req,
	input  logic [HAND_W-1:0]    rep_player [NUM_LANES],
	input  logic [HAND_W-1:0]    rep_dealer [NUM_LANES],
	input  outcome_t             rep_outcome [NUM_LANES],
	input  logic                 result_ack,
	output logic [NUM_LANES-1:0] rep_ack,
	output logic                 result_req,
	output logic [LANE_W-1:0]    result_lane,
	output logic [HAND_W-1:0]    result_player,
	output logic [HAND_W-1:0]    result_dealer,
	output outcome_t             result_outcome,
	output logic                 idle
);

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_LANE,
		ARB_HOST,
		ARB_DROP
	} arb_state_t;

	arb_state_t        state;
	logic [LANE_W-1:0] pick;
	logic              pick_valid;

	// Nearest requester after the last lane served
	always_comb begin
		int idx;
		pick       = result_lane;
		pick_valid = 1'b0;
		// Walk backwards so the closest lane wins
		for (int k = NUM_LANES; k >= 1; k--) begin
			idx = (int'(result_lane) + k) % NUM_LANES;
			if (rep_req[idx]) begin
				pick       = LANE_W'(idx);
				pick_valid = 1'b1;
			end
		end
	end

	assign rep_ack    = (state == ARB_LANE) ? (NUM_LANES'(1) << result_lane) : '0;
	assign result_req = (state == ARB_HOST);
	assign idle       = (state == ARB_IDLE);

	// Report copy taken at grant time
	always_ff @(posedge CLOCK_50) begin
		if (state == ARB_IDLE && pick_valid) begin
			result_player  <= rep_player[pick];
			result_dealer  <= rep_dealer[pick];
			result_outcome <= rep_outcome[pick];
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			state       <= ARB_IDLE;
			// Rotation pointer, first search starts at lane 0
			result_lane <= LANE_W'(NUM_LANES - 1);
		end else begin
			case (state)
				ARB_IDLE: begin
					if (pick_valid) begin
						result_lane <= pick;
						state       <= ARB_LANE;
					end
				end
				// Lane side handshake
				ARB_LANE: if (!rep_req[result_lane]) state <= ARB_HOST;
				// Host side handshake
				ARB_HOST: if (result_ack) state <= ARB_DROP;
				ARB_DROP: if (!result_ack) state <= ARB_IDLE;
				default: state <= ARB_IDLE;
			endcase
		end
	end

endmodule

//--- tb_blackjack.sv
// Blackjack engine testbench
// Runs a table of deck patterns and game counts through the DUT:
// reset, deck load, start, report acknowledge, wait for the run to end

`timescale 1ns/1ps

module tb_blackjack import bj_pkg::*; ();

	localparam int NUM_LANES   = 4;
	localparam int LANE_W      = 2;
	localparam int NUM_TESTS   = 5;
	localparam int LOAD_LIMIT  = 20;
	localparam int RUN_LIMIT   = 200000;
	localparam int FLAG_ACK    = 0;
	localparam int FLAG_LOADED = 1;
	localparam int FLAG_BUSY   = 2;
	localparam logic [31:0] SEED = 32'h3090_1650;

	//////////////////////////////////////////////////////////////////////
	// Stimulus table with one column per array and pattern 0 as random 2..11
	//////////////////////////////////////////////////////////////////////

	logic [127:0] name_tab    [NUM_TESTS] = '{"tens", "elevens", "sixes",
		"random_slow", "random_fast"};
	int           pattern_tab [NUM_TESTS] = '{10, 11, 6, 0, 0};
	int           games_tab   [NUM_TESTS] = '{3, 3, 3, 8, 5};
	logic         slow_tab    [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
	logic         any_tab     [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
	int           player_tab  [NUM_TESTS] = '{20, 22, 12, 0, 0};
	int           dealer_tab  [NUM_TESTS] = '{20, 11, 18, 0, 0};
	outcome_t     outcome_tab [NUM_TESTS] = '{TIE, LOSS, LOSS, LOSS, LOSS};

	// DUT side
	logic              CLOCK_50;
	logic              reset;
	logic              load_req;
	logic [CARD_W-1:0] load_value;
	logic              start;
	logic [GAME_W-1:0] games_per_lane;
	logic              result_ack;
	logic              load_ack;
	logic              deck_loaded;
	logic              busy;
	logic              result_req;
	logic [LANE_W-1:0] result_lane;
	logic [HAND_W-1:0] result_player;
	logic [HAND_W-1:0] result_dealer;
	outcome_t          result_outcome;

	// Checker side
	logic [127:0]      test_name;
	logic              exp_any;
	logic [HAND_W-1:0] exp_player;
	logic [HAND_W-1:0] exp_dealer;
	outcome_t          exp_outcome;
	logic              test_end;
	logic              run_end;
	int                error_count;

	// Ack responder and run state
	logic slow_ack;
	int   ack_wait;
	logic hung;

	initial CLOCK_50 = 1'b0;
	always #4 CLOCK_50 = ~CLOCK_50;

	blackjack_sim #(.NUM_LANES(NUM_LANES)) dut (
		.CLOCK_50       (CLOCK_50),
		.reset          (reset),
		.load_req       (load_req),
		.load_value     (load_value),
		.start          (start),
		.games_per_lane (games_per_lane),
		.result_ack     (result_ack),
		.load_ack       (load_ack),
		.deck_loaded    (deck_loaded),
		.busy           (busy),
		.result_req     (result_req),
		.result_lane    (result_lane),
		.result_player  (result_player),
		.result_dealer  (result_dealer),
		.result_outcome (result_outcome)
	);

	bj_checker #(.NUM_LANES(NUM_LANES)) chk (
		.CLOCK_50       (CLOCK_50),
		.reset          (reset),
		.load_ack       (load_ack),
		.deck_loaded    (deck_loaded),
		.busy           (busy),
		.result_req     (result_req),
		.result_lane    (result_lane),
		.result_player  (result_player),
		.result_dealer  (result_dealer),
		.result_outcome (result_outcome),
		.test_name      (test_name),
		.games_per_lane (games_per_lane),
		.exp_any        (exp_any),
		.exp_player     (exp_player),
		.exp_dealer     (exp_dealer),
		.exp_outcome    (exp_outcome),
		.test_end       (test_end),
		.run_end        (run_end),
		.error_count    (error_count)
	);

	// Host side of the result handshake with optional random hold-off
	always @(posedge CLOCK_50) begin
		if (reset) begin
			result_ack <= 1'b0;
			ack_wait   <= 0;
		end else if (result_req && !result_ack) begin
			if (ack_wait == 0) begin
				result_ack <= 1'b1;
			end else begin
				ack_wait <= ack_wait - 1;
			end
		end else if (!result_req && result_ack) begin
			result_ack <= 1'b0;
			// Delay for the next report
			ack_wait   <= slow_ack ? int'($urandom % 8) : 0;
		end
	end

	function automatic logic flag_value(input int which);
		case (which)
			FLAG_ACK:    return load_ack;
			FLAG_LOADED: return deck_loaded;
			default:     return busy;
		endcase
	endfunction

	task automatic note_timeout(input string what);
		if (!hung) begin
			hung = 1'b1;
			$display("timeout: %s", what);
		end
	endtask

	// Poll a DUT flag once per clock until the limit
	task automatic await_flag(input int which, input logic level, input int limit,
			input string what);
		int cycles;
		cycles = 0;
		while (!hung && flag_value(which) !== level) begin
			@(posedge CLOCK_50);
			cycles++;
			if (cycles > limit) begin
				note_timeout(what);
			end
		end
	endtask

	// Run end wait with a start pulse during each report acknowledge
	task automatic wait_run_end();
		int cycles;
		cycles = 0;
		while (!hung && busy !== 1'b0) begin
			@(posedge CLOCK_50);
			// Lanes already finished sit in IDLE here
			start <= result_req && result_ack;
			cycles++;
			if (cycles > RUN_LIMIT) begin
				note_timeout("busy did not fall at the end of the run");
			end
		end
		start <= 1'b0;
	endtask

	// One full deck over the load handshake
	task automatic load_deck(input int pattern);
		for (int c = 0; c < DECK_SIZE; c++) begin
			if (!hung) begin
				load_value <= (pattern == 0) ? CARD_W'(2 + $urandom % 10) : CARD_W'(pattern);
				load_req   <= 1'b1;
				await_flag(FLAG_ACK, 1'b1, LOAD_LIMIT, "load_ack did not rise");
				load_req <= 1'b0;
				await_flag(FLAG_ACK, 1'b0, LOAD_LIMIT, "load_ack did not fall");
			end
		end
	endtask

	task automatic run_test(input int t);
		@(posedge CLOCK_50);
		reset          <= 1'b1;
		test_name      <= name_tab[t];
		slow_ack       <= slow_tab[t];
		exp_any        <= any_tab[t];
		exp_player     <= HAND_W'(player_tab[t]);
		exp_dealer     <= HAND_W'(dealer_tab[t]);
		exp_outcome    <= outcome_tab[t];
		games_per_lane <= GAME_W'(games_tab[t]);
		repeat (3) @(posedge CLOCK_50);
		reset <= 1'b0;
		// Loader keeps its deck until reset so every test reloads
		load_deck(pattern_tab[t]);
		await_flag(FLAG_LOADED, 1'b1, LOAD_LIMIT, "deck_loaded did not rise");
		@(posedge CLOCK_50);
		start <= 1'b1;
		@(posedge CLOCK_50);
		start <= 1'b0;
		await_flag(FLAG_BUSY, 1'b1, LOAD_LIMIT, "busy did not rise after start");
		// Extra starts while busy must add no reports
		wait_run_end();
		@(posedge CLOCK_50);
		test_end <= 1'b1;
		@(posedge CLOCK_50);
		test_end <= 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(SEED));
		reset          = 1'b1;
		load_req       = 1'b0;
		load_value     = '0;
		start          = 1'b0;
		games_per_lane = '0;
		result_ack     = 1'b0;
		test_name      = '0;
		exp_any        = 1'b0;
		exp_player     = '0;
		exp_dealer     = '0;
		exp_outcome    = LOSS;
		test_end       = 1'b0;
		run_end        = 1'b0;
		slow_ack       = 1'b0;
		hung           = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			if (!hung) begin
				run_test(t);
			end
		end
		@(posedge CLOCK_50);
		run_end <= 1'b1;
		@(posedge CLOCK_50);
		run_end <= 1'b0;
		@(posedge CLOCK_50);
		if (!hung && error_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
